// ==== common/decode_pkg.sv ====
// Decode stage shared widths, opcodes, operation codes and decoded-instruction type
package decode_pkg;

    localparam int xlen          = 32;
    localparam int num_warps     = 4;
    localparam int wid_w         = $clog2(num_warps);
    localparam int num_threads   = 4; // Also the thread mask width
    localparam int nr_bits       = 5;
    localparam int csr_addr_bits = 12;
    localparam int op_bits       = 4;
    localparam int mod_bits      = 3;

    // RV32 major opcodes
    localparam logic [6:0] opc_i     = 7'b0010011;
    localparam logic [6:0] opc_r     = 7'b0110011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_b     = 7'b1100011;
    localparam logic [6:0] opc_l     = 7'b0000011;
    localparam logic [6:0] opc_s     = 7'b0100011;
    localparam logic [6:0] opc_fence = 7'b0001111;
    localparam logic [6:0] opc_sys   = 7'b1110011;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    // ALU operations
    localparam logic [op_bits-1:0] alu_add   = 4'b0000;
    localparam logic [op_bits-1:0] alu_lui   = 4'b0010;
    localparam logic [op_bits-1:0] alu_auipc = 4'b0011;
    localparam logic [op_bits-1:0] alu_sltu  = 4'b0100;
    localparam logic [op_bits-1:0] alu_slt   = 4'b0101;
    localparam logic [op_bits-1:0] alu_srl   = 4'b1000;
    localparam logic [op_bits-1:0] alu_sra   = 4'b1001;
    localparam logic [op_bits-1:0] alu_sub   = 4'b1011;
    localparam logic [op_bits-1:0] alu_and   = 4'b1100;
    localparam logic [op_bits-1:0] alu_or    = 4'b1101;
    localparam logic [op_bits-1:0] alu_xor   = 4'b1110;
    localparam logic [op_bits-1:0] alu_sll   = 4'b1111;

    // Branch, jump and system operations
    localparam logic [op_bits-1:0] br_eq     = 4'b0000;
    localparam logic [op_bits-1:0] br_ne     = 4'b0010;
    localparam logic [op_bits-1:0] br_ltu    = 4'b0100;
    localparam logic [op_bits-1:0] br_lt     = 4'b0101;
    localparam logic [op_bits-1:0] br_geu    = 4'b0110;
    localparam logic [op_bits-1:0] br_ge     = 4'b0111;
    localparam logic [op_bits-1:0] br_jal    = 4'b1000;
    localparam logic [op_bits-1:0] br_jalr   = 4'b1001;
    localparam logic [op_bits-1:0] br_ecall  = 4'b1010;
    localparam logic [op_bits-1:0] br_ebreak = 4'b1011;
    localparam logic [op_bits-1:0] br_uret   = 4'b1100;
    localparam logic [op_bits-1:0] br_sret   = 4'b1101;
    localparam logic [op_bits-1:0] br_mret   = 4'b1110;

    // Multiply and divide, same order as func3
    localparam logic [op_bits-1:0] m_mul    = 4'd0;
    localparam logic [op_bits-1:0] m_mulh   = 4'd1;
    localparam logic [op_bits-1:0] m_mulhsu = 4'd2;
    localparam logic [op_bits-1:0] m_mulhu  = 4'd3;
    localparam logic [op_bits-1:0] m_div    = 4'd4;
    localparam logic [op_bits-1:0] m_divu   = 4'd5;
    localparam logic [op_bits-1:0] m_rem    = 4'd6;
    localparam logic [op_bits-1:0] m_remu   = 4'd7;

    localparam logic [op_bits-1:0] lsu_fence = 4'd15;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_FOUR, IMM_NONE
    } imm_fmt_e;

    typedef struct packed {
        ex_type_e              ex_type;
        logic [op_bits-1:0]    op_type;
        logic [mod_bits-1:0]   op_mod;
        logic                  use_pc;
        logic                  use_imm;
        logic                  wb;
        logic [nr_bits-1:0]    rd;
        logic [nr_bits-1:0]    rs1;
        logic [nr_bits-1:0]    rs2;
        logic [xlen-1:0]       imm;
    } uop_t;

endpackage

// ==== common/uop_if.sv ====
// Decoded instruction channel with valid/ready handshake
`timescale 1ns/1ps

interface uop_if;
    import decode_pkg::*;

    logic                   valid;
    logic                   ready;
    logic [wid_w-1:0]       wid;
    logic [xlen-1:0]        pc;
    logic [num_threads-1:0] tmask;
    uop_t                   uop;

    modport producer (
        output valid,
        output wid,
        output pc,
        output tmask,
        output uop,
        input  ready
    );

    modport consumer (
        input  valid,
        input  wid,
        input  pc,
        input  tmask,
        input  uop,
        output ready
    );

endinterface

// ==== hw/decode/func_decoder.sv ====
// Operation lookup tables for ALU, branch, multiply/divide and system instructions
`timescale 1ns/1ps

module func_decoder (
    input  logic [31:0] instr,
    output logic [3:0]  alu_op,
    output logic [3:0]  br_op,
    output logic [3:0]  m_op,
    output logic [3:0]  sys_op
);
    import decode_pkg::*;

    logic [2:0]  func3;
    logic        alt;    // func7 bit 5
    logic        is_op;
    logic [11:0] sys_field;

    assign func3     = instr[14:12];
    assign alt       = instr[30];
    assign is_op     = (instr[6:0] == opc_r);
    assign sys_field = instr[31:20];

    always_comb begin
        case (func3)
            3'h0: alu_op = (is_op && alt) ? alu_sub : alu_add;
            3'h1: alu_op = alu_sll;
            3'h2: alu_op = alu_slt;
            3'h3: alu_op = alu_sltu;
            3'h4: alu_op = alu_xor;
            3'h5: alu_op = alt ? alu_sra : alu_srl;
            3'h6: alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

    always_comb begin
        case (func3)
            3'h1: br_op = br_ne;
            3'h4: br_op = br_lt;
            3'h5: br_op = br_ge;
            3'h6: br_op = br_ltu;
            3'h7: br_op = br_geu;
            default: br_op = br_eq; // 2 and 3 are reserved
        endcase
    end

    assign m_op = {1'b0, func3}; // m_mul .. m_remu follow func3

    always_comb begin
        case (sys_field)
            12'h001: sys_op = br_ebreak;
            12'h002: sys_op = br_uret;
            12'h102: sys_op = br_sret;
            12'h302: sys_op = br_mret;
            default: sys_op = br_ecall;
        endcase
    end

endmodule

// ==== hw/decode/imm_gen.sv ====
// Immediate builder, sign-extends each RISC-V immediate format to 32 bits
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:0]          instr,
    input  decode_pkg::imm_fmt_e fmt,
    output logic [31:0]          imm
);
    import decode_pkg::*;

    logic        is_shift;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    // SLLI, SRLI, SRAI
    assign is_shift = (instr[6:0] == opc_i) && instr[12] && !instr[13];

    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (fmt)
            IMM_I: begin
                if (is_shift)
                    imm = {{(xlen-nr_bits){1'b0}}, instr[24:20]};
                else
                    imm = {{(xlen-12){i_imm[11]}}, i_imm};
            end
            IMM_S:    imm = {{(xlen-12){s_imm[11]}}, s_imm};
            IMM_B:    imm = {{(xlen-13){b_imm[12]}}, b_imm};
            IMM_U:    imm = {instr[31:12], 12'b0};
            IMM_J:    imm = {{(xlen-21){j_imm[20]}}, j_imm};
            IMM_CSR:  imm = {{(xlen-csr_addr_bits-nr_bits){1'b0}}, instr[19:15], instr[31:20]};
            IMM_FOUR: imm = 32'd4;
            default:  imm = '0;
        endcase
    end

endmodule

// ==== hw/decode/op_decoder.sv ====
// Main opcode decoder, builds the decoded instruction and the warp stall strobe
`timescale 1ns/1ps

module op_decoder (
    input  logic                               fetch_valid,
    output logic                               fetch_ready,
    input  logic [31:0]                        fetch_instr,
    input  logic [decode_pkg::xlen-1:0]        fetch_pc,
    input  logic [decode_pkg::wid_w-1:0]       fetch_wid,
    input  logic [decode_pkg::num_threads-1:0] fetch_tmask,
    input  logic [3:0]                         alu_op,
    input  logic [3:0]                         br_op,
    input  logic [3:0]                         m_op,
    input  logic [3:0]                         sys_op,
    input  logic [31:0]                        imm,
    output decode_pkg::imm_fmt_e               fmt,
    output logic                               sched_valid,
    output logic [decode_pkg::wid_w-1:0]       sched_wid,
    output logic                               sched_wstall,
    uop_if.producer                            out
);
    import decode_pkg::*;

    logic [6:0]         opcode;
    logic [2:0]         func3;
    logic               m_ext;
    logic [nr_bits-1:0] rd;
    logic [nr_bits-1:0] rs1;
    logic [nr_bits-1:0] rs2;
    logic               use_rd;
    logic               use_rs1;
    logic               use_rs2;
    logic               is_wstall;
    uop_t               uop;

    assign opcode = fetch_instr[6:0];
    assign func3  = fetch_instr[14:12];
    assign m_ext  = fetch_instr[25]; // func7 bit 0
    assign rd     = fetch_instr[11:7];
    assign rs1    = fetch_instr[19:15];
    assign rs2    = fetch_instr[24:20];

    always_comb begin
        uop       = '0;
        uop.ex_type = EX_ALU;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;
        fmt       = IMM_NONE;

        case (opcode)
            opc_i: begin
                uop.op_type = alu_op;
                uop.use_imm = 1'b1;
                fmt         = IMM_I;
                use_rd      = 1'b1;
                use_rs1     = 1'b1;
            end
            opc_r: begin
                if (m_ext) begin
                    uop.op_type   = m_op;
                    uop.op_mod[1] = 1'b1;
                end else begin
                    uop.op_type = alu_op;
                end
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            opc_lui, opc_auipc: begin
                uop.op_type = opcode[5] ? alu_lui : alu_auipc;
                uop.use_pc  = !opcode[5];
                uop.use_imm = 1'b1;
                fmt         = IMM_U;
                use_rd      = 1'b1;
            end
            opc_jal: begin
                uop.op_type   = br_jal;
                uop.op_mod[0] = 1'b1;
                uop.use_pc    = 1'b1;
                uop.use_imm   = 1'b1;
                fmt           = IMM_J;
                use_rd        = 1'b1;
                is_wstall     = 1'b1;
            end
            opc_jalr: begin
                uop.op_type   = br_jalr;
                uop.op_mod[0] = 1'b1;
                uop.use_imm   = 1'b1;
                fmt           = IMM_I;
                use_rd        = 1'b1;
                use_rs1       = 1'b1;
                is_wstall     = 1'b1;
            end
            opc_b: begin
                uop.op_type   = br_op;
                uop.op_mod[0] = 1'b1;
                uop.use_pc    = 1'b1;
                uop.use_imm   = 1'b1;
                fmt           = IMM_B;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                is_wstall     = 1'b1;
            end
            opc_l: begin
                uop.ex_type = EX_LSU;
                uop.op_type = {1'b0, func3};
                uop.use_imm = 1'b1;
                fmt         = IMM_I;
                use_rd      = 1'b1;
                use_rs1     = 1'b1;
            end
            opc_s: begin
                uop.ex_type = EX_LSU;
                uop.op_type = {1'b1, func3};
                uop.use_imm = 1'b1;
                fmt         = IMM_S;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            opc_fence: begin
                uop.ex_type = EX_LSU;
                uop.op_type = lsu_fence;
            end
            opc_sys: begin
                is_wstall = 1'b1;
                use_rd    = 1'b1;
                if (func3[1:0] != 2'b00) begin // CSR access
                    uop.ex_type = EX_SFU;
                    uop.op_type = {2'b00, func3[1:0]};
                    uop.use_imm = func3[2];
                    fmt         = IMM_CSR;
                    use_rs1     = !func3[2];
                end else begin
                    uop.op_type   = sys_op;
                    uop.op_mod[0] = 1'b1;
                    uop.use_pc    = 1'b1;
                    uop.use_imm   = 1'b1;
                    fmt           = IMM_FOUR; // Return address offset
                end
            end
            default: ;
        endcase

        uop.rd  = use_rd  ? rd  : '0;
        uop.rs1 = use_rs1 ? rs1 : '0;
        uop.rs2 = use_rs2 ? rs2 : '0;
        uop.wb  = use_rd && (rd != '0); // No write to x0
        uop.imm = imm;
    end

    assign out.valid = fetch_valid;
    assign out.wid   = fetch_wid;
    assign out.pc    = fetch_pc;
    assign out.tmask = fetch_tmask;
    assign out.uop   = uop;

    assign fetch_ready  = out.ready;
    assign sched_valid  = fetch_valid && out.ready;
    assign sched_wid    = fetch_wid;
    assign sched_wstall = is_wstall;

endmodule

// ==== hw/decode_buffer.sv ====
// One-entry registered output stage with valid/ready handshake
`timescale 1ns/1ps

module decode_buffer (
    input  logic                               clk,
    input  logic                               rst_n,
    uop_if.consumer                            in,
    output logic                               dec_valid,
    input  logic                               dec_ready,
    output logic [decode_pkg::wid_w-1:0]       dec_wid,
    output logic [decode_pkg::xlen-1:0]        dec_pc,
    output logic [decode_pkg::num_threads-1:0] dec_tmask,
    output decode_pkg::uop_t                   dec_uop
);

    logic valid_q;
    logic load;

    // Empty or draining this cycle
    assign in.ready = !valid_q || dec_ready;
    assign load     = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in.ready) begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_wid   <= in.wid;
            dec_pc    <= in.pc;
            dec_tmask <= in.tmask;
            dec_uop   <= in.uop;
        end
    end

    assign dec_valid = valid_q;

endmodule

// ==== hw/decode_top.sv ====
// Instruction decode stage top, fetch in, decoded uop out, scheduler stall strobe
`timescale 1ns/1ps

module decode_top (
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic                               fetch_valid,
    output logic                               fetch_ready,
    input  logic [31:0]                        fetch_instr,
    input  logic [decode_pkg::xlen-1:0]        fetch_pc,
    input  logic [decode_pkg::wid_w-1:0]       fetch_wid,
    input  logic [decode_pkg::num_threads-1:0] fetch_tmask,

    output logic                               dec_valid,
    input  logic                               dec_ready,
    output logic [decode_pkg::wid_w-1:0]       dec_wid,
    output logic [decode_pkg::xlen-1:0]        dec_pc,
    output logic [decode_pkg::num_threads-1:0] dec_tmask,
    output decode_pkg::uop_t                   dec_uop,

    output logic                               sched_valid,
    output logic [decode_pkg::wid_w-1:0]       sched_wid,
    output logic                               sched_wstall
);
    import decode_pkg::*;

    logic [3:0]  alu_op;
    logic [3:0]  br_op;
    logic [3:0]  m_op;
    logic [3:0]  sys_op;
    logic [31:0] imm;
    imm_fmt_e    fmt;

    uop_if dec_if ();

    func_decoder u_func_decoder (
        .instr  (fetch_instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .m_op   (m_op),
        .sys_op (sys_op)
    );

    imm_gen u_imm_gen (
        .instr (fetch_instr),
        .fmt   (fmt),
        .imm   (imm)
    );

    op_decoder u_op_decoder (
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .fetch_wid    (fetch_wid),
        .fetch_tmask  (fetch_tmask),
        .alu_op       (alu_op),
        .br_op        (br_op),
        .m_op         (m_op),
        .sys_op       (sys_op),
        .imm          (imm),
        .fmt          (fmt),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall),
        .out          (dec_if.producer)
    );

    decode_buffer u_decode_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (dec_if.consumer),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_wid   (dec_wid),
        .dec_pc    (dec_pc),
        .dec_tmask (dec_tmask),
        .dec_uop   (dec_uop)
    );

endmodule

// ==== tests/decode_assertions.sv ====
// Decode stage handshake, back-pressure and scheduler strobe properties
`timescale 1ns/1ps

module decode_assertions (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               fetch_valid,
    input logic                               fetch_ready,
    input logic                               dec_valid,
    input logic                               dec_ready,
    input logic [decode_pkg::wid_w-1:0]       dec_wid,
    input logic [decode_pkg::xlen-1:0]        dec_pc,
    input logic [decode_pkg::num_threads-1:0] dec_tmask,
    input decode_pkg::uop_t                   dec_uop,
    input logic                               sched_valid
);

    // Stalled entry keeps every output
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_wid) && $stable(dec_pc)
            && $stable(dec_tmask) && $stable(dec_uop))
        else $error("dec outputs changed while the entry was stalled");

    // Accepted instruction shows up after the edge
    a_accept: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && fetch_ready |=> dec_valid)
        else $error("dec_valid low after a fetch transfer");

    a_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |-> !fetch_ready && !sched_valid)
        else $error("fetch accepted while the output was stalled");

    a_reset: assert property (@(posedge clk) !rst_n |=> !dec_valid)
        else $error("dec_valid high after a reset cycle");

endmodule

bind decode_top decode_assertions u_decode_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_wid     (dec_wid),
    .dec_pc      (dec_pc),
    .dec_tmask   (dec_tmask),
    .dec_uop     (dec_uop),
    .sched_valid (sched_valid)
);

// ==== tests/tb_decode.sv ====
// Decode stage testbench that replays stimulus records under random back-pressure
`timescale 1ns/1ps

module tb_decode;
    import decode_pkg::*;

    localparam int num_recs   = 31;
    localparam int rec_words  = 15;  // Columns per stimulus line
    localparam int max_cycles = 20 * num_recs + 50;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_valid;
    logic                   fetch_ready;
    logic [31:0]            fetch_instr;
    logic [xlen-1:0]        fetch_pc;
    logic [wid_w-1:0]       fetch_wid;
    logic [num_threads-1:0] fetch_tmask;
    logic                   dec_valid;
    logic                   dec_ready;
    logic [wid_w-1:0]       dec_wid;
    logic [xlen-1:0]        dec_pc;
    logic [num_threads-1:0] dec_tmask;
    uop_t                   dec_uop;
    logic                   sched_valid;
    logic [wid_w-1:0]       sched_wid;
    logic                   sched_wstall;

    logic [31:0] stim_mem [0:num_recs*rec_words-1];
    logic [31:0] lcg_state;
    int          send_idx;
    int          out_idx     = 0;
    int          sched_idx   = 0;
    int          cycle_count = 0;
    logic        exp_full    = 1'b0; // Expected occupancy of the output entry
    logic        exp_ready;
    logic        after_reset = 1'b0;

    decode_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_instr  (fetch_instr),
        .fetch_pc     (fetch_pc),
        .fetch_wid    (fetch_wid),
        .fetch_tmask  (fetch_tmask),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_wid      (dec_wid),
        .dec_pc       (dec_pc),
        .dec_tmask    (dec_tmask),
        .dec_uop      (dec_uop),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_wstall (sched_wstall)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] stim_word(input int rec, input int col);
        return stim_mem[rec*rec_words + col];
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_output(input int r);
        expect_equal("dec_pc", 32'(dec_pc), stim_word(r, 1));
        expect_equal("dec_wid", 32'(dec_wid), stim_word(r, 2));
        expect_equal("dec_tmask", 32'(dec_tmask), stim_word(r, 3));
        expect_equal("dec_uop.ex_type", 32'(dec_uop.ex_type), stim_word(r, 5));
        expect_equal("dec_uop.op_type", 32'(dec_uop.op_type), stim_word(r, 6));
        expect_equal("dec_uop.op_mod", 32'(dec_uop.op_mod), stim_word(r, 7));
        expect_equal("dec_uop.use_pc", 32'(dec_uop.use_pc), stim_word(r, 8));
        expect_equal("dec_uop.use_imm", 32'(dec_uop.use_imm), stim_word(r, 9));
        expect_equal("dec_uop.wb", 32'(dec_uop.wb), stim_word(r, 10));
        expect_equal("dec_uop.rd", 32'(dec_uop.rd), stim_word(r, 11));
        expect_equal("dec_uop.rs1", 32'(dec_uop.rs1), stim_word(r, 12));
        expect_equal("dec_uop.rs2", 32'(dec_uop.rs2), stim_word(r, 13));
        expect_equal("dec_uop.imm", dec_uop.imm, stim_word(r, 14));
    endtask

    // Driver
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc    = '0;
        fetch_wid   = '0;
        fetch_tmask = '0;
        dec_ready   = 1'b1;
        lcg_state   = 32'h9706cf93;
        send_idx    = 0;
        $readmemh("tests/decode_stim.txt", stim_mem);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (send_idx < num_recs) begin
            @(posedge clk);
            if (fetch_valid && fetch_ready)
                send_idx++;
            lcg_state = lcg_step(lcg_state);
            dec_ready <= (lcg_state[31:16] % 16'd3) != 16'd0; // Low a third of the time
            lcg_state = lcg_step(lcg_state);
            if (!fetch_valid || fetch_ready) begin // Otherwise hold until taken
                if (send_idx == num_recs || lcg_state[31:28] < 4'd3) begin
                    fetch_valid <= 1'b0;
                end else begin
                    fetch_valid <= 1'b1;
                    fetch_instr <= stim_word(send_idx, 0);
                    fetch_pc    <= stim_word(send_idx, 1);
                    fetch_wid   <= wid_w'(stim_word(send_idx, 2));
                    fetch_tmask <= num_threads'(stim_word(send_idx, 3));
                end
            end
        end
        forever begin
            @(posedge clk);
            lcg_state = lcg_step(lcg_state);
            dec_ready <= (lcg_state[31:16] % 16'd3) != 16'd0;
        end
    end

    // Values sampled before the edge updates them
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("Timeout after %0d cycles with %0d of %0d records out",
                     cycle_count, out_idx, num_recs);
            abort_run();
        end
        exp_ready = !exp_full || dec_ready;
        if (!rst_n) begin
            if (cycle_count > 1) // Entry unknown before the first edge
                expect_equal("dec_valid", 32'(dec_valid), 32'd0);
            expect_equal("sched_valid", 32'(sched_valid), 32'd0);
            expect_equal("fetch_ready", 32'(fetch_ready), 32'd1);
            after_reset = 1'b1;
            exp_full    = 1'b0;
        end else begin
            if (after_reset) begin
                expect_equal("dec_valid", 32'(dec_valid), 32'd0);
                expect_equal("sched_valid", 32'(sched_valid), 32'd0);
                expect_equal("fetch_ready", 32'(fetch_ready), 32'd1);
                after_reset = 1'b0;
            end
            expect_equal("dec_valid", 32'(dec_valid), 32'(exp_full));
            expect_equal("fetch_ready", 32'(fetch_ready), 32'(exp_ready));
            expect_equal("sched_valid", 32'(sched_valid), 32'(fetch_valid && exp_ready));
            if (sched_valid) begin
                if (sched_idx >= num_recs) begin
                    $display("More scheduler strobes than records sent");
                    abort_run();
                end
                expect_equal("sched_wid", 32'(sched_wid), stim_word(sched_idx, 2));
                expect_equal("sched_wstall", 32'(sched_wstall), stim_word(sched_idx, 4));
                sched_idx++;
            end
            // Entry fills on a transfer and empties when drained
            if (fetch_valid && exp_ready)
                exp_full = 1'b1;
            else if (dec_ready)
                exp_full = 1'b0;
            if (dec_valid && dec_ready) begin
                check_output(out_idx);
                out_idx++;
                if (out_idx == num_recs) begin
                    expect_equal("sched count", 32'(sched_idx), 32'(num_recs));
                    $display("Everything OK");
                    $finish;
                end
            end
        end
    end

endmodule

// ==== tests/decode_stim.txt ====
// instr pc wid tmask stall | ex_type op_type op_mod use_pc use_imm wb rd rs1 rs2 imm
// One instruction per line, all hex, expected decoded fields after the stall flag
00500093 00001000 0 f 0  0 0 0 0 1 1 01 00 00 00000005
00711193 00001004 1 1 0  0 f 0 0 1 1 03 02 00 00000007
41f1d213 00001008 2 3 0  0 9 0 0 1 1 04 03 00 0000001f
80024293 0000100c 3 7 0  0 e 0 0 1 1 05 04 00 fffff800
40028313 00001010 0 8 0  0 0 0 0 1 1 06 05 00 00000400
00730433 00001014 1 c 0  0 0 0 0 0 1 08 06 07 00000000
401404b3 00001018 2 e 0  0 b 0 0 0 1 09 08 01 00000000
4024d533 0000101c 3 5 0  0 9 0 0 0 1 0a 09 02 00000000
0020b033 00001020 0 f 0  0 4 0 0 0 0 00 01 02 00000000
022085b3 00001024 1 1 0  0 0 2 0 0 1 0b 01 02 00000000
0241a633 00001028 2 3 0  0 2 2 0 0 1 0c 03 04 00000000
0262d6b3 0000102c 3 7 0  0 5 2 0 0 1 0d 05 06 00000000
0283f733 00001030 0 8 0  0 7 2 0 0 1 0e 07 08 00000000
deadb7b7 00001034 1 c 0  0 2 0 0 1 1 0f 00 00 deadb000
12345817 00001038 2 e 0  0 3 0 1 1 1 10 00 00 12345000
00208463 0000103c 3 5 1  0 0 1 1 1 0 00 01 02 00000008
fe419ee3 00001040 0 f 1  0 2 1 1 1 0 00 03 04 fffffffc
0062e0e3 00001044 1 1 1  0 4 1 1 1 0 00 05 06 00000800
001000ef 00001048 2 3 1  0 8 1 1 1 1 01 00 00 00000800
ff9ff06f 0000104c 3 7 1  0 8 1 1 1 0 00 00 00 fffffff8
00c280e7 00001050 0 8 1  0 9 1 0 1 1 01 05 00 0000000c
ffc12883 00001054 1 c 0  1 2 0 0 1 1 11 02 00 fffffffc
00532423 00001058 2 e 0  1 a 0 0 1 0 00 06 05 00000008
fe740fa3 0000105c 3 5 0  1 8 0 0 1 0 00 08 07 ffffffff
0ff0000f 00001060 0 f 0  1 f 0 0 0 0 00 00 00 00000000
00000073 00001064 1 1 1  0 a 1 1 1 0 00 00 00 00000004
30200073 00001068 2 3 1  0 e 1 1 1 0 00 00 00 00000004
30049973 0000106c 3 7 1  2 1 0 0 0 1 12 09 00 00009300
3422e9f3 00001070 0 8 1  2 2 0 0 1 1 13 00 00 00005342
c000b073 00001074 1 c 1  2 3 0 0 0 0 00 01 00 00001c00
0000007f 00001078 2 e 0  0 0 0 0 0 0 00 00 00 00000000

// ==== sim.f ====
common/decode_pkg.sv
common/uop_if.sv
hw/decode/func_decoder.sv
hw/decode/imm_gen.sv
hw/decode/op_decoder.sv
hw/decode_buffer.sv
hw/decode_top.sv
tests/decode_assertions.sv
tests/tb_decode.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_decode -Mdir obj_dir \
    && ./obj_dir/Vtb_decode | tee sim.log \
    || echo "Build or simulation stopped with an error"
grep -q "^Everything OK$" sim.log && echo "Test passed" || { echo "Test failed"; exit 1; }
